// ==== tb.f ====
verilog/desPkg.sv
verilog/desKeySchedule.sv
verilog/desFeistelRound.sv
verilog/desCore.sv
verilog/desApbRegs.sv
verilog/desApbTop.sv
dv/tbDesApb.sv

// ==== Makefile ====
TOOL   = verilator
FLAGS  = --binary -j 0
TOP    = tbDesApb
FLIST  = tb.f
OBJDIR = obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf $(OBJDIR)

// ==== dv/tbDesApb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbDesApb;

  localparam int numRandom = 200;
  localparam int numOps    = 2 * numRandom + 8;
  localparam int timeoutNs = numOps * 40 * 4 * 2;

  logic            clk;
  logic            rst;
  logic            pSel;
  logic            pEnable;
  logic            pWrite;
  logic [7:0]      pAddr;
  desPkg::apbDataT pWdata;
  desPkg::apbDataT pRdata;
  logic            pReady;
  logic            pSlverr;

  int              errors;
  string           nameQ [$];
  desPkg::blockT   expQ [$];
  desPkg::blockT   actQ [$];

  desApbTop #(
    .addrWidth (8)
  ) i_desApbTop (
    .clk     (clk),
    .rst     (rst),
    .pSel    (pSel),
    .pEnable (pEnable),
    .pWrite  (pWrite),
    .pAddr   (pAddr),
    .pWdata  (pWdata),
    .pRdata  (pRdata),
    .pReady  (pReady),
    .pSlverr (pSlverr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // behavioral DES, all 16 subkeys first, then the rounds.
  function automatic desPkg::blockT desRef(desPkg::blockT key, desPkg::blockT block,
                                           logic dec);
    desPkg::subkeyT ks [16];
    desPkg::subkeyT x;
    desPkg::cdT     c;
    desPkg::cdT     d;
    desPkg::halfT   l;
    desPkg::halfT   r;
    desPkg::halfT   s;
    desPkg::halfT   f;
    desPkg::halfT   t;
    desPkg::blockT  ip;
    desPkg::blockT  pre;
    desPkg::blockT  out;
    logic [55:0]    cd;
    logic [5:0]     six;
    int             idx;
    for (int i = 0; i < 56; i++) cd[55 - i] = key[64 - desPkg::pc1Table[i]];
    c = cd[55:28];
    d = cd[27:0];
    for (int n = 0; n < 16; n++) begin
      repeat (desPkg::shiftOneMask[n] ? 1 : 2) begin
        c = {c[26:0], c[27]};
        d = {d[26:0], d[27]};
      end
      cd = {c, d};
      for (int i = 0; i < 48; i++) ks[n][47 - i] = cd[56 - desPkg::pc2Table[i]];
    end
    for (int i = 0; i < 64; i++) ip[63 - i] = block[64 - desPkg::ipTable[i]];
    l = ip[63:32];
    r = ip[31:0];
    for (int n = 0; n < 16; n++) begin
      for (int i = 0; i < 48; i++) x[47 - i] = r[32 - desPkg::eTable[i]];
      x = x ^ ks[dec ? 15 - n : n];
      for (int b = 0; b < 8; b++) begin
        six = x[47 - 6 * b -: 6];
        idx = int'({six[5], six[0], six[4:1]});
        s[31 - 4 * b -: 4] = desPkg::sboxTable[b][255 - 4 * idx -: 4];
      end
      for (int i = 0; i < 32; i++) f[31 - i] = s[32 - desPkg::pTable[i]];
      t = l ^ f;
      l = r;
      r = t;
    end
    pre = {r, l};
    for (int i = 0; i < 64; i++) out[63 - i] = pre[64 - desPkg::fpTable[i]];
    return out;
  endfunction

  function automatic logic [7:0] regAddr(logic [4:0] offset);
    return {3'b000, offset};
  endfunction

  task automatic expectEq(string name, desPkg::blockT exp, desPkg::blockT act);
    nameQ.push_back(name);
    expQ.push_back(exp);
    actQ.push_back(act);
  endtask

  // setup cycle, then access cycle sampled at the falling edge.
  task automatic apbAccess(input logic write, input logic [7:0] addr,
                           input desPkg::apbDataT wdata,
                           output desPkg::apbDataT rdata, output logic err);
    @(posedge clk);
    pSel    <= 1'b1;
    pEnable <= 1'b0;
    pWrite  <= write;
    pAddr   <= addr;
    pWdata  <= wdata;
    @(posedge clk);
    pEnable <= 1'b1;
    @(negedge clk);
    rdata = pRdata;
    err   = pSlverr;
    expectEq("apb pready", 64'd1, 64'(pReady));
    @(posedge clk);
    pSel    <= 1'b0;
    pEnable <= 1'b0;
    pWrite  <= 1'b0;
  endtask

  task automatic apbWrite(input logic [7:0] addr, input desPkg::apbDataT data,
                          output logic err);
    desPkg::apbDataT unused;
    apbAccess(1'b1, addr, data, unused, err);
  endtask

  task automatic apbRead(input logic [7:0] addr, output desPkg::apbDataT data,
                         output logic err);
    apbAccess(1'b0, addr, '0, data, err);
  endtask

  task automatic loadOperands(input desPkg::blockT key, input desPkg::blockT block);
    logic err;
    apbWrite(regAddr(desPkg::regKeyHi), key[63:32], err);
    apbWrite(regAddr(desPkg::regKeyLo), key[31:0], err);
    apbWrite(regAddr(desPkg::regDataHi), block[63:32], err);
    apbWrite(regAddr(desPkg::regDataLo), block[31:0], err);
  endtask

  // poll until the sticky done bit shows up.
  task automatic waitDone;
    desPkg::apbDataT status;
    logic            err;
    status = '0;
    while (status[1] == 1'b0) apbRead(regAddr(desPkg::regStatus), status, err);
  endtask

  task automatic readResult(output desPkg::blockT result);
    desPkg::apbDataT hi;
    desPkg::apbDataT lo;
    logic            err;
    apbRead(regAddr(desPkg::regResultHi), hi, err);
    apbRead(regAddr(desPkg::regResultLo), lo, err);
    result = {hi, lo};
  endtask

  task automatic runOp(input string name, input desPkg::blockT key,
                       input desPkg::blockT block, input logic dec,
                       output desPkg::blockT result);
    logic err;
    loadOperands(key, block);
    apbWrite(regAddr(desPkg::regCtrl), {30'd0, dec, 1'b1}, err);
    expectEq({name, " start slverr"}, 64'd0, 64'(err));
    waitDone();
    readResult(result);
  endtask

  initial begin
    string         name;
    desPkg::blockT exp;
    desPkg::blockT act;
    forever begin
      @(posedge clk);
      while (nameQ.size() > 0) begin
        name = nameQ.pop_front();
        exp  = expQ.pop_front();
        act  = actQ.pop_front();
        assert (act === exp) else begin
          $display("ERROR %s: expected %h, actual %h", name, exp, act);
          errors++;
        end
      end
    end
  end

  initial begin
    #(timeoutNs);
    $display("watchdog expired after %0d ns, operations did not complete", timeoutNs);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    desPkg::blockT   key;
    desPkg::blockT   pt;
    desPkg::blockT   ct;
    desPkg::blockT   back;
    desPkg::apbDataT word;
    desPkg::apbDataT wr [4];
    logic            err;
    errors  = 0;
    rst     = 1'b1;
    pSel    = 1'b0;
    pEnable = 1'b0;
    pWrite  = 1'b0;
    pAddr   = '0;
    pWdata  = '0;
    void'($urandom(44131));
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    apbRead(regAddr(desPkg::regStatus), word, err);
    expectEq("reset status", 64'd0, 64'(word));
    readResult(back);
    expectEq("reset result", 64'd0, back);
    for (int i = 0; i < 4; i++) wr[i] = $urandom;
    for (int i = 0; i < 4; i++) apbWrite(regAddr(5'(4 * i)), wr[i], err);
    for (int i = 0; i < 4; i++) begin
      apbRead(regAddr(5'(4 * i)), word, err);
      expectEq("operand readback", 64'(wr[i]), 64'(word));
    end

    // FIPS worked example.
    key = 64'h133457799BBCDFF1;
    runOp("kat encrypt", key, 64'h0123456789ABCDEF, 1'b0, ct);
    expectEq("kat encrypt", 64'h85E813540F0AB405, ct);
    expectEq("kat reference", 64'h85E813540F0AB405, desRef(key, 64'h0123456789ABCDEF, 1'b0));
    runOp("kat decrypt", key, 64'h85E813540F0AB405, 1'b1, back);
    expectEq("kat decrypt", 64'h0123456789ABCDEF, back);

    for (int n = 0; n < numRandom; n++) begin
      key = {$urandom, $urandom};
      pt  = {$urandom, $urandom};
      runOp("random encrypt", key, pt, 1'b0, ct);
      expectEq("random encrypt", desRef(key, pt, 1'b0), ct);
      runOp("random decrypt", key, ct, 1'b1, back);
      expectEq("random decrypt", desRef(key, ct, 1'b1), back);
      expectEq("random roundtrip", pt, back);
    end

    // second start while busy must be rejected.
    key = {$urandom, $urandom};
    pt  = {$urandom, $urandom};
    loadOperands(key, pt);
    apbWrite(regAddr(desPkg::regCtrl), 32'h1, err);
    expectEq("busy first start slverr", 64'd0, 64'(err));
    apbWrite(regAddr(desPkg::regCtrl), 32'h3, err);
    expectEq("busy second start slverr", 64'd1, 64'(err));
    // busy set, done cleared by the accepted start.
    apbRead(regAddr(desPkg::regStatus), word, err);
    expectEq("busy status", 64'd1, 64'(word));
    waitDone();
    readResult(ct);
    expectEq("busy result", desRef(key, pt, 1'b0), ct);

    apbRead(8'h20, word, err);
    expectEq("unmapped read slverr", 64'd1, 64'(err));
    apbWrite(regAddr(desPkg::regResultLo), ~ct[31:0], err);
    expectEq("result write slverr", 64'd1, 64'(err));
    readResult(back);
    expectEq("result after write", ct, back);

    repeat (3) @(posedge clk);
    $display("checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/desApbTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module desApbTop #(
  parameter int addrWidth = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 pSel,
  input  logic                 pEnable,
  input  logic                 pWrite,
  input  logic [addrWidth-1:0] pAddr,
  input  desPkg::apbDataT      pWdata,
  output desPkg::apbDataT      pRdata,
  output logic                 pReady,
  output logic                 pSlverr
);

  logic          start;
  logic          decrypt;
  logic          busy;
  logic          done;
  desPkg::blockT key;
  desPkg::blockT dataIn;
  desPkg::blockT dataOut;

  desApbRegs #(
    .addrWidth (addrWidth)
  ) i_desApbRegs (
    .clk     (clk),
    .rst     (rst),
    .pSel    (pSel),
    .pEnable (pEnable),
    .pWrite  (pWrite),
    .pAddr   (pAddr),
    .pWdata  (pWdata),
    .pRdata  (pRdata),
    .pReady  (pReady),
    .pSlverr (pSlverr),
    .start   (start),
    .decrypt (decrypt),
    .key     (key),
    .dataIn  (dataIn),
    .busy    (busy),
    .done    (done),
    .dataOut (dataOut)
  );

  desCore i_desCore (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .decrypt (decrypt),
    .key     (key),
    .dataIn  (dataIn),
    .busy    (busy),
    .done    (done),
    .dataOut (dataOut)
  );

endmodule

`default_nettype wire

// ==== verilog/desApbRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module desApbRegs #(
  parameter int addrWidth = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 pSel,
  input  logic                 pEnable,
  input  logic                 pWrite,
  input  logic [addrWidth-1:0] pAddr,
  input  desPkg::apbDataT      pWdata,
  output desPkg::apbDataT      pRdata,
  output logic                 pReady,
  output logic                 pSlverr,
  output logic                 start,
  output logic                 decrypt,
  output desPkg::blockT        key,
  output desPkg::blockT        dataIn,
  input  logic                 busy,
  input  logic                 done,
  input  desPkg::blockT        dataOut
);

  logic            access;
  logic            mapped;
  logic            badAccess;
  logic            wrEn;
  logic [4:0]      offset;
  logic            decryptReg;
  logic            doneFlag;
  desPkg::blockT   keyReg;
  desPkg::blockT   dataReg;
  desPkg::blockT   resultReg;
  desPkg::apbDataT readData;

  assign access = pSel & pEnable;
  assign offset = pAddr[4:0];
  assign mapped = (pAddr >> 5) == '0;

  always_comb begin
    readData  = '0;
    badAccess = 1'b0;
    if (!mapped) begin
      badAccess = 1'b1;
    end else begin
      case (offset)
        desPkg::regKeyHi:  readData = keyReg[63:32];
        desPkg::regKeyLo:  readData = keyReg[31:0];
        desPkg::regDataHi: readData = dataReg[63:32];
        desPkg::regDataLo: readData = dataReg[31:0];
        desPkg::regCtrl: begin
          readData  = {30'd0, decryptReg, 1'b0};
          badAccess = pWrite & pWdata[0] & busy;
        end
        desPkg::regStatus: begin
          readData  = {30'd0, doneFlag, busy};
          badAccess = pWrite;
        end
        desPkg::regResultHi: begin
          readData  = resultReg[63:32];
          badAccess = pWrite;
        end
        desPkg::regResultLo: begin
          readData  = resultReg[31:0];
          badAccess = pWrite;
        end
        default: badAccess = 1'b1;
      endcase
    end
  end

  assign pRdata  = readData;
  assign pReady  = 1'b1;
  assign pSlverr = access & badAccess;
  assign wrEn    = access & pWrite & ~badAccess;

  // start only reaches here while the core is idle.
  assign start   = wrEn & (offset == desPkg::regCtrl) & pWdata[0];
  assign decrypt = start ? pWdata[1] : decryptReg;
  assign key     = keyReg;
  assign dataIn  = dataReg;

  always_ff @(posedge clk) begin
    if (rst) begin
      keyReg     <= '0;
      dataReg    <= '0;
      resultReg  <= '0;
      decryptReg <= 1'b0;
      doneFlag   <= 1'b0;
    end else begin
      if (wrEn) begin
        case (offset)
          desPkg::regKeyHi:  keyReg[63:32]  <= pWdata;
          desPkg::regKeyLo:  keyReg[31:0]   <= pWdata;
          desPkg::regDataHi: dataReg[63:32] <= pWdata;
          desPkg::regDataLo: dataReg[31:0]  <= pWdata;
          desPkg::regCtrl:   decryptReg     <= pWdata[1];
          default: ;
        endcase
      end
      // sticky until the next accepted start.
      if (done) begin
        resultReg <= dataOut;
        doneFlag  <= 1'b1;
      end else if (start) begin
        doneFlag  <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/desCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module desCore (
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  logic          decrypt,
  input  desPkg::blockT key,
  input  desPkg::blockT dataIn,
  output logic          busy,
  output logic          done,
  output desPkg::blockT dataOut
);

  desPkg::coreStateT state;
  desPkg::roundT     roundCnt;
  logic              lastStep;
  logic              dirReg;
  logic              keyDecrypt;
  logic              advance;
  desPkg::blockT     permIn;
  desPkg::blockT     preOut;
  desPkg::halfT      left;
  desPkg::halfT      right;
  desPkg::halfT      newLeft;
  desPkg::halfT      newRight;
  desPkg::subkeyT    subkey;

  always_comb begin
    for (int i = 0; i < 64; i++) begin
      permIn[63 - i] = dataIn[64 - desPkg::ipTable[i]];
    end
  end

  // halves swapped back after round 16.
  assign preOut = {right, left};

  always_comb begin
    for (int i = 0; i < 64; i++) begin
      dataOut[63 - i] = preOut[64 - desPkg::fpTable[i]];
    end
  end

  assign busy       = state == desPkg::run;
  assign done       = busy & lastStep;
  assign advance    = busy & ~lastStep;
  assign keyDecrypt = start ? decrypt : dirReg;

  desKeySchedule i_desKeySchedule (
    .clk     (clk),
    .rst     (rst),
    .load    (start),
    .advance (advance),
    .decrypt (keyDecrypt),
    .key     (key),
    .subkey  (subkey)
  );

  desFeistelRound i_desFeistelRound (
    .left     (left),
    .right    (right),
    .subkey   (subkey),
    .newLeft  (newLeft),
    .newRight (newRight)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= desPkg::idle;
      roundCnt <= '0;
      lastStep <= 1'b0;
      dirReg   <= 1'b0;
    end else begin
      case (state)
        desPkg::idle: begin
          if (start) begin
            state    <= desPkg::run;
            roundCnt <= '0;
            lastStep <= 1'b0;
            dirReg   <= decrypt;
          end
        end
        default: begin
          if (lastStep) begin
            state    <= desPkg::idle;
            lastStep <= 1'b0;
          end else begin
            roundCnt <= roundCnt + 1'b1;
            lastStep <= roundCnt == desPkg::roundT'(desPkg::numRounds - 1);
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      {left, right} <= permIn;
    end else if (advance) begin
      left  <= newLeft;
      right <= newRight;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/desFeistelRound.sv ====
`timescale 1ns/1ps
`default_nettype none

module desFeistelRound (
  input  desPkg::halfT   left,
  input  desPkg::halfT   right,
  input  desPkg::subkeyT subkey,
  output desPkg::halfT   newLeft,
  output desPkg::halfT   newRight
);

  desPkg::subkeyT  expanded;
  desPkg::subkeyT  mixed;
  desPkg::halfT    sboxOut;
  desPkg::halfT    permuted;
  desPkg::sboxInT  sIn;
  desPkg::sboxOutT sOut;

  always_comb begin
    for (int i = 0; i < 48; i++) begin
      expanded[47 - i] = right[32 - desPkg::eTable[i]];
    end
  end

  assign mixed = expanded ^ subkey;

  // outer bits pick the row, inner four the column.
  always_comb begin
    int entry;
    sIn = '0;
    sOut = '0;
    for (int b = 0; b < 8; b++) begin
      sIn = mixed[47 - 6 * b -: 6];
      entry = {sIn[5], sIn[0], sIn[4:1]};
      sOut = desPkg::sboxTable[b][255 - 4 * entry -: 4];
      sboxOut[31 - 4 * b -: 4] = sOut;
    end
  end

  always_comb begin
    for (int i = 0; i < 32; i++) begin
      permuted[31 - i] = sboxOut[32 - desPkg::pTable[i]];
    end
  end

  assign newLeft  = right;
  assign newRight = left ^ permuted;

endmodule

`default_nettype wire

// ==== verilog/desKeySchedule.sv ====
`timescale 1ns/1ps
`default_nettype none

module desKeySchedule (
  input  logic           clk,
  input  logic           rst,
  input  logic           load,
  input  logic           advance,
  input  logic           decrypt,
  input  desPkg::blockT  key,
  output desPkg::subkeyT subkey
);

  desPkg::cdT    c;
  desPkg::cdT    d;
  desPkg::cdT    cPc1;
  desPkg::cdT    dPc1;
  desPkg::roundT round;
  logic [55:0]   pc1Out;
  logic [55:0]   cd;
  logic          shiftOne;

  function automatic desPkg::cdT rotl(desPkg::cdT x, logic one);
    return one ? {x[26:0], x[27]} : {x[25:0], x[27:26]};
  endfunction

  function automatic desPkg::cdT rotr(desPkg::cdT x, logic one);
    return one ? {x[0], x[27:1]} : {x[1:0], x[27:2]};
  endfunction

  always_comb begin
    for (int i = 0; i < 56; i++) begin
      pc1Out[55 - i] = key[64 - desPkg::pc1Table[i]];
    end
  end

  assign cPc1 = pc1Out[55:28];
  assign dPc1 = pc1Out[27:0];
  assign cd   = {c, d};

  always_comb begin
    for (int i = 0; i < 48; i++) begin
      subkey[47 - i] = cd[56 - desPkg::pc2Table[i]];
    end
  end

  // decrypt walks back, undoing the rotation of the round just used.
  assign shiftOne = decrypt ? desPkg::shiftOneMask[~round]
                            : desPkg::shiftOneMask[round + 1'b1];

  always_ff @(posedge clk) begin
    if (rst) begin
      round <= '0;
    end else if (load) begin
      round <= '0;
    end else if (advance) begin
      round <= round + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      if (decrypt) begin
        c <= cPc1;
        d <= dPc1;
      end else begin
        c <= rotl(cPc1, desPkg::shiftOneMask[0]);
        d <= rotl(dPc1, desPkg::shiftOneMask[0]);
      end
    end else if (advance) begin
      if (decrypt) begin
        c <= rotr(c, shiftOne);
        d <= rotr(d, shiftOne);
      end else begin
        c <= rotl(c, shiftOne);
        d <= rotl(d, shiftOne);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/desPkg.sv ====
`default_nettype none

package desPkg;

  typedef logic [63:0] blockT;
  typedef logic [31:0] halfT;
  typedef logic [27:0] cdT;
  typedef logic [47:0] subkeyT;
  typedef logic [5:0]  sboxInT;
  typedef logic [3:0]  sboxOutT;
  typedef logic [3:0]  roundT;
  typedef logic [31:0] apbDataT;

  typedef enum logic {
    idle,
    run
  } coreStateT;

  localparam int numRounds = 16;

  // bit indices count from 1 at the msb, as in FIPS 46.
  localparam int ipTable [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
  };

  localparam int fpTable [64] = '{
    40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25
  };

  localparam int eTable [48] = '{
    32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
     8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
    24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
  };

  localparam int pTable [32] = '{
    16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
     2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
  };

  localparam int pc1Table [56] = '{
    57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
    10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
    14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
  };

  localparam int pc2Table [48] = '{
    14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
    23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
    41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
    44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
  };

  // entry 0 in the top nibble, index is row * 16 + column.
  localparam logic [255:0] sboxTable [8] = '{
    256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
    256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
    256'hA09E63F51DC7B428_D70934A6285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
    256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
    256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
    256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
    256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
    256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
  };

  // bit n set means round n + 1 rotates by one place.
  localparam logic [15:0] shiftOneMask = 16'h8103;

  localparam logic [4:0] regKeyHi    = 5'h00;
  localparam logic [4:0] regKeyLo    = 5'h04;
  localparam logic [4:0] regDataHi   = 5'h08;
  localparam logic [4:0] regDataLo   = 5'h0C;
  localparam logic [4:0] regCtrl     = 5'h10;
  localparam logic [4:0] regStatus   = 5'h14;
  localparam logic [4:0] regResultHi = 5'h18;
  localparam logic [4:0] regResultLo = 5'h1C;

endpackage

`default_nettype wire
